//--- common/ex_pkg.sv
/*
 * Shared definitions for the two-lane execute stage.
 * ALU function codes, operand select codes, branch condition codes,
 * the instruction word with its three format views, and the structs
 * passed between issue, lanes, multipliers and the result arbiter.
 * Modules pull these in with a wildcard import in their header.
 */
package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // ALU function codes
  localparam logic [4:0] ALU_ADDQ   = 5'h00;
  localparam logic [4:0] ALU_SUBQ   = 5'h01;
  localparam logic [4:0] ALU_AND    = 5'h02;
  localparam logic [4:0] ALU_BIC    = 5'h03;   // a & ~b
  localparam logic [4:0] ALU_BIS    = 5'h04;   // Plain or
  localparam logic [4:0] ALU_ORNOT  = 5'h05;
  localparam logic [4:0] ALU_XOR    = 5'h06;
  localparam logic [4:0] ALU_EQV    = 5'h07;   // xnor
  localparam logic [4:0] ALU_SRL    = 5'h08;
  localparam logic [4:0] ALU_SLL    = 5'h09;
  localparam logic [4:0] ALU_SRA    = 5'h0a;
  localparam logic [4:0] ALU_MULQ   = 5'h0b;   // Goes to the multiplier
  localparam logic [4:0] ALU_CMPEQ  = 5'h0c;
  localparam logic [4:0] ALU_CMPLT  = 5'h0d;
  localparam logic [4:0] ALU_CMPLE  = 5'h0e;
  localparam logic [4:0] ALU_CMPULT = 5'h0f;
  localparam logic [4:0] ALU_CMPULE = 5'h10;   // Highest legal code

  // Operand A select
  localparam logic [1:0] OPA_IS_REGA     = 2'd0;
  localparam logic [1:0] OPA_IS_MEM_DISP = 2'd1;
  localparam logic [1:0] OPA_IS_NPC      = 2'd2;
  localparam logic [1:0] OPA_IS_NOT3     = 2'd3;

  // Operand B select, code 3 illegal
  localparam logic [1:0] OPB_IS_REGB    = 2'd0;
  localparam logic [1:0] OPB_IS_ALU_IMM = 2'd1;
  localparam logic [1:0] OPB_IS_BR_DISP = 2'd2;

  // Branch conditions, low opcode bits, tested on rega
  localparam logic [2:0] COND_LBC = 3'd0;   // Low bit clear
  localparam logic [2:0] COND_EQ  = 3'd1;
  localparam logic [2:0] COND_LT  = 3'd2;
  localparam logic [2:0] COND_LE  = 3'd3;
  localparam logic [2:0] COND_LBS = 3'd4;   // Low bit set
  localparam logic [2:0] COND_NE  = 3'd5;
  localparam logic [2:0] COND_GE  = 3'd6;
  localparam logic [2:0] COND_GT  = 3'd7;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word views
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [15:0] disp;
  } mem_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;   // Low 3 bits are the condition
    logic [4:0]  ra;
    logic [20:0] disp;     // Longword displacement
  } br_fmt_t;

  // rb and the literal share bits 20:13 of an operate word
  typedef union packed {
    struct packed {
      logic [4:0] rb;
      logic [2:0] sbz;
    } reg_src;
    logic [7:0] lit;
  } op_src_u;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    op_src_u    src;
    logic       is_lit;
    logic [6:0] func;
    logic [4:0] rc;
  } op_fmt_t;

  typedef union packed {
    mem_fmt_t mem;
    br_fmt_t  br;
    op_fmt_t  op;
  } inst_word_u;

  ////////////////////////////////////////////////////////////////////////////
  // Stage structs
  typedef struct packed {
    logic        valid;
    logic [63:0] npc;             // PC + 4
    logic [63:0] ppc;             // Predicted next PC
    inst_word_u  ir;
    logic [4:0]  dest_reg;
    logic [63:0] rega;
    logic [63:0] regb;
    logic [1:0]  opa_sel;
    logic [1:0]  opb_sel;
    logic [4:0]  alu_func;
    logic        cond_branch;
    logic        uncond_branch;
  } issue_pkt_t;

  // On the way out mplier holds the product
  typedef struct packed {
    logic        valid;
    logic [4:0]  dest_reg;
    logic [63:0] mplier;
    logic [63:0] mcand;
  } mult_req_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  dest_reg;
    logic [63:0] value;
    logic        mispredict;
  } ex_result_t;

endpackage

//--- design/alu.sv
/*
 * Combinational 64-bit integer ALU.
 * Logic, shift, add/sub and compare functions on two operands.
 * Multiplies are done elsewhere, so MULQ and unknown codes give zero.
 */
`timescale 1ns/1ps

module alu import ex_pkg::*; (
  input  logic [63:0] opa,
  input  logic [63:0] opb,
  input  logic [4:0]  func,
  output logic [63:0] result
);

  logic signed [63:0] sopa;   // Signed views for compares and sra
  logic signed [63:0] sopb;
  logic        [5:0]  shamt;  // Shift count, low 6 bits of opb

  assign sopa  = opa;
  assign sopb  = opb;
  assign shamt = opb[5:0];

  always_comb
  begin
    case (func)
      ALU_ADDQ:   result = opa + opb;
      ALU_SUBQ:   result = opa - opb;
      ALU_AND:    result = opa & opb;
      ALU_BIC:    result = opa & ~opb;
      ALU_BIS:    result = opa | opb;
      ALU_ORNOT:  result = opa | ~opb;
      ALU_XOR:    result = opa ^ opb;
      ALU_EQV:    result = opa ^ ~opb;
      ALU_SRL:    result = opa >> shamt;
      ALU_SLL:    result = opa << shamt;
      ALU_SRA:    result = sopa >>> shamt;   // Fills with sign
      // Compares return 0 or 1
      ALU_CMPEQ:  result = {63'b0, opa == opb};
      ALU_CMPLT:  result = {63'b0, sopa < sopb};
      ALU_CMPLE:  result = {63'b0, sopa <= sopb};
      ALU_CMPULT: result = {63'b0, opa < opb};
      ALU_CMPULE: result = {63'b0, opa <= opb};
      ALU_MULQ:   result = '0;   // Product comes from mult_pipe
      default:    result = '0;
    endcase
  end

endmodule

//--- design/ex_lane/branch_resolve.sv
/*
 * Branch resolution for one lane.
 * Tests the condition on rega, picks the correct next PC and flags
 * a mispredict whenever it differs from the predicted PC.
 */
`timescale 1ns/1ps

module branch_resolve import ex_pkg::*; (
  input  logic [63:0] rega,
  input  logic [2:0]  cond_code,
  input  logic        cond_branch,
  input  logic        uncond_branch,
  input  logic [63:0] target,       // npc + br_disp from the ALU
  input  logic [63:0] npc,
  input  logic [63:0] ppc,
  output logic        mispredict
);

  logic        zero;
  logic        cond_true;
  logic        taken;
  logic [63:0] correct_pc;

  assign zero = (rega == 64'b0);

  always_comb
  begin
    case (cond_code)
      COND_LBC: cond_true = ~rega[0];
      COND_EQ:  cond_true = zero;
      COND_LT:  cond_true = rega[63];
      COND_LE:  cond_true = rega[63] | zero;
      COND_LBS: cond_true = rega[0];
      COND_NE:  cond_true = ~zero;
      COND_GE:  cond_true = ~rega[63];
      default:  cond_true = ~rega[63] & ~zero;   // COND_GT
    endcase
  end

  assign taken      = uncond_branch | (cond_branch & cond_true);
  assign correct_pc = taken ? target : npc;
  assign mispredict = (correct_pc != ppc);   // Applies to every op

  // Decoder marks a branch as one kind only
  always_comb
  begin
    assert (!(cond_branch && uncond_branch))
      else $error("branch_resolve: cond and uncond branch both set");
  end

endmodule

//--- design/ex_lane/ex_lane.sv
/*
 * One execute lane.
 * Carves the immediates out of the instruction word, selects the two
 * ALU operands, runs the ALU and branch resolution, and splits the op
 * into an ALU result or a multiply request for this lane's multiplier.
 */
`timescale 1ns/1ps

module ex_lane import ex_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  issue_pkt_t issue,
  output ex_result_t alu_out,
  output mult_req_t  mult_req
);

  logic [63:0] mem_disp;
  logic [63:0] br_disp;
  logic [63:0] alu_imm;
  logic [63:0] opa;
  logic [63:0] opb;
  logic [63:0] alu_result;
  logic        mispredict;
  logic        is_mulq;

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  assign mem_disp = {{48{issue.ir.mem.disp[15]}}, issue.ir.mem.disp};
  assign br_disp  = {{41{issue.ir.br.disp[20]}}, issue.ir.br.disp, 2'b00};   // x4
  assign alu_imm  = {56'b0, issue.ir.op.src.lit};                           // Zero extended

  // Operand A
  always_comb
  begin
    case (issue.opa_sel)
      OPA_IS_REGA:     opa = issue.rega;
      OPA_IS_MEM_DISP: opa = mem_disp;
      OPA_IS_NPC:      opa = issue.npc;
      default:         opa = ~64'h3;   // Longword align mask
    endcase
  end

  // Operand B
  always_comb
  begin
    case (issue.opb_sel)
      OPB_IS_REGB:    opb = issue.regb;
      OPB_IS_ALU_IMM: opb = alu_imm;
      OPB_IS_BR_DISP: opb = br_disp;
      default:        opb = '0;        // Illegal select
    endcase
  end

  alu alu_inst (
    .opa    (opa),
    .opb    (opb),
    .func   (issue.alu_func),
    .result (alu_result)
  );

  branch_resolve branch_resolve_inst (
    .rega          (issue.rega),
    .cond_code     (issue.ir.br.opcode[2:0]),
    .cond_branch   (issue.cond_branch),
    .uncond_branch (issue.uncond_branch),
    .target        (alu_result),
    .npc           (issue.npc),
    .ppc           (issue.ppc),
    .mispredict    (mispredict)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Split between ALU result and multiply
  assign is_mulq = (issue.alu_func == ALU_MULQ);

  assign alu_out.valid      = issue.valid & ~is_mulq;
  assign alu_out.dest_reg   = issue.dest_reg;
  assign alu_out.value      = alu_result;
  assign alu_out.mispredict = mispredict;

  assign mult_req.valid    = issue.valid & is_mulq;
  assign mult_req.dest_reg = issue.dest_reg;
  assign mult_req.mplier   = opa;   // Same operands the ALU sees
  assign mult_req.mcand    = opb;

  // Decoder side contract on every valid issue
  assert property (@(posedge clock) disable iff (!rst_n)
    issue.valid |-> issue.opb_sel != 2'd3)
    else $error("ex_lane: illegal opb_sel");

  assert property (@(posedge clock) disable iff (!rst_n)
    issue.valid |-> issue.alu_func <= ALU_CMPULE)
    else $error("ex_lane: unknown alu_func %0h", issue.alu_func);

endmodule

//--- design/ex_stage.sv
/*
 * Two-lane execute stage, top level.
 * Each lane feeds its ALU result and its own pipelined multiplier;
 * the arbiter merges both onto one registered result bus per lane and
 * stalls issue on a collision. MULT_STAGES sets the multiplier depth.
 */
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
  parameter int MULT_STAGES = 4
) (
  input  logic       clock,
  input  logic       rst_n,
  input  issue_pkt_t issue_1,
  input  issue_pkt_t issue_2,
  output ex_result_t result_1,
  output ex_result_t result_2,
  output logic       stall_1,
  output logic       stall_2
);

  ex_result_t alu_out_1, alu_out_2;
  mult_req_t  mult_req_1, mult_req_2;
  mult_req_t  mult_done_1, mult_done_2;

  ////////////////////////////////////////////////////////////////////////////
  // Lanes
  ex_lane ex_lane_1 (
    .clock    (clock),
    .rst_n    (rst_n),
    .issue    (issue_1),
    .alu_out  (alu_out_1),
    .mult_req (mult_req_1)
  );

  ex_lane ex_lane_2 (
    .clock    (clock),
    .rst_n    (rst_n),
    .issue    (issue_2),
    .alu_out  (alu_out_2),
    .mult_req (mult_req_2)
  );

  // One multiplier per lane
  mult_pipe #(.MULT_STAGES(MULT_STAGES)) mult_pipe_1 (
    .clock (clock),
    .rst_n (rst_n),
    .req   (mult_req_1),
    .done  (mult_done_1)
  );

  mult_pipe #(.MULT_STAGES(MULT_STAGES)) mult_pipe_2 (
    .clock (clock),
    .rst_n (rst_n),
    .req   (mult_req_2),
    .done  (mult_done_2)
  );

  result_arbiter result_arbiter_inst (
    .clock    (clock),
    .rst_n    (rst_n),
    .alu_1    (alu_out_1),
    .alu_2    (alu_out_2),
    .mult_1   (mult_done_1),
    .mult_2   (mult_done_2),
    .result_1 (result_1),
    .result_2 (result_2),
    .stall_1  (stall_1),
    .stall_2  (stall_2)
  );

endmodule

//--- design/mult/mult_pipe.sv
/*
 * Pipelined 64x64 multiplier, low half of the product.
 * Each stage takes the next slice of the multiplier, multiplies it by
 * the shifted multiplicand and adds it into a running sum. Always
 * advances. The product leaves in the mplier field of done.
 */
`timescale 1ns/1ps

module mult_pipe import ex_pkg::*; #(
  parameter int MULT_STAGES = 4      // 1, 2, 4 or 8
) (
  input  logic      clock,
  input  logic      rst_n,
  input  mult_req_t req,
  output mult_req_t done
);

  localparam int          SLICE      = 64 / MULT_STAGES;
  localparam logic [63:0] SLICE_MASK = (64'd1 << SLICE) - 64'd1;  // All ones at 64

  // Stage registers; mplier holds what is left of the multiplier
  mult_req_t   stage    [MULT_STAGES];
  logic [63:0] sum      [MULT_STAGES];
  mult_req_t   stage_in [MULT_STAGES];
  logic [63:0] sum_in   [MULT_STAGES];

  // Stage inputs, first one straight from the request
  always_comb
  begin
    stage_in[0] = req;
    sum_in[0]   = '0;
    for (int s = 1; s < MULT_STAGES; s++)
    begin
      stage_in[s] = stage[s-1];
      sum_in[s]   = sum[s-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline
  always_ff @(posedge clock)
  begin
    for (int s = 0; s < MULT_STAGES; s++)
    begin
      if (!rst_n)
        stage[s].valid <= 1'b0;
      else
        stage[s].valid <= stage_in[s].valid;
      stage[s].dest_reg <= stage_in[s].dest_reg;
      stage[s].mcand    <= stage_in[s].mcand << SLICE;    // Align to next slice
      stage[s].mplier   <= stage_in[s].mplier >> SLICE;   // Drop used slice
      // Partial product of this slice, low 64 bits
      sum[s] <= sum_in[s] + stage_in[s].mcand * (stage_in[s].mplier & SLICE_MASK);
    end
  end

  assign done.valid    = stage[MULT_STAGES-1].valid;
  assign done.dest_reg = stage[MULT_STAGES-1].dest_reg;
  assign done.mplier   = sum[MULT_STAGES-1];   // Product
  assign done.mcand    = '0;

endmodule

//--- design/result_arbiter.sv
/*
 * Result bus arbiter for both lanes.
 * Each lane has one registered result bus. A finished multiply always
 * wins; an ALU result in the same cycle is refused and the lane's stall
 * goes high so issue holds the op until the bus is free.
 */
`timescale 1ns/1ps

module result_arbiter import ex_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  ex_result_t alu_1,
  input  ex_result_t alu_2,
  input  mult_req_t  mult_1,
  input  mult_req_t  mult_2,
  output ex_result_t result_1,
  output ex_result_t result_2,
  output logic       stall_1,
  output logic       stall_2
);

  ex_result_t alu_in  [2];
  mult_req_t  mult_in [2];
  ex_result_t bus     [2];   // Registered result buses
  logic [1:0] stall;

  assign alu_in[0]  = alu_1;
  assign alu_in[1]  = alu_2;
  assign mult_in[0] = mult_1;
  assign mult_in[1] = mult_2;

  // Collision per lane
  always_comb
  begin
    for (int i = 0; i < 2; i++)
      stall[i] = mult_in[i].valid & alu_in[i].valid;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus registers, multiplier first
  always_ff @(posedge clock)
  begin
    for (int i = 0; i < 2; i++)
    begin
      if (!rst_n)
        bus[i].valid <= 1'b0;
      else
        bus[i].valid <= mult_in[i].valid | alu_in[i].valid;
      if (mult_in[i].valid)
      begin
        bus[i].dest_reg   <= mult_in[i].dest_reg;
        bus[i].value      <= mult_in[i].mplier;   // Product
        bus[i].mispredict <= 1'b0;
      end
      else
        bus[i].dest_reg   <= alu_in[i].dest_reg;
      if (!mult_in[i].valid)
      begin
        bus[i].value      <= alu_in[i].value;
        bus[i].mispredict <= alu_in[i].mispredict;
      end
    end
  end

  assign result_1 = bus[0];
  assign result_2 = bus[1];
  assign stall_1  = stall[0];
  assign stall_2  = stall[1];

  // Refused ALU op must still be presented, unchanged, after the stall
  for (genvar i = 0; i < 2; i++)
  begin : g_chk
    assert property (@(posedge clock) disable iff (!rst_n)
      stall[i] |=> alu_in[i].valid
                   && alu_in[i].dest_reg == $past(alu_in[i].dest_reg)
                   && alu_in[i].value == $past(alu_in[i].value))
      else $error("result_arbiter: lane %0d lost the ALU op refused under stall", i + 1);
  end

endmodule

//--- flist.f
common/ex_pkg.sv
design/alu.sv
design/ex_lane/branch_resolve.sv
design/ex_lane/ex_lane.sv
design/mult/mult_pipe.sv
design/result_arbiter.sv
design/ex_stage.sv
testbench/clock_gen.sv
testbench/ex_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; success only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module ex_stage_tb \
  -o ex_stage_tb_sim &&
./obj_dir/ex_stage_tb_sim | tee /dev/stderr | grep -q "All checks passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

//--- testbench/clock_gen.sv
/*
 * Clock and reset source for the execute stage testbench.
 * 10 ns clock, rst_n held low for RESET_CYCLES rising edges and then
 * released at a rising edge, as the synchronous reset expects.
 */
`timescale 1ns/1ps

module clock_gen #(
  parameter int RESET_CYCLES = 3
) (
  output logic clock,
  output logic rst_n
);

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;   // 10 ns period
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    rst_n <= 1'b1;
  end

endmodule

//--- testbench/ex_stage_tb.sv
/*
 * Testbench for the two-lane execute stage.
 * Drives both lanes on the falling edge, keeps a per-lane scoreboard of
 * expected results keyed by dest_reg, and checks value, mispredict and
 * arrival cycle of every result on the buses. Run through run.sh.
 */
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

  localparam int MULT_STAGES    = 4;
  localparam int TIMEOUT_CYCLES = 4000;   // ~600 ops at up to 5 cycles, with margin

  logic       clock;
  logic       rst_n;
  issue_pkt_t issue_1, issue_2;
  ex_result_t result_1, result_2;
  logic       stall_1, stall_2;

  // Scoreboard per lane, indexed by dest_reg
  ex_result_t exp_res   [2][32];
  int         due       [2][32];   // Cycle at which the result must show
  logic       in_flight [2][32];
  int         cyc, checks, errors, test_checks, test_errors;
  int         stalls_seen [2];
  string      test_name;

  clock_gen #(.RESET_CYCLES(3)) clock_gen_inst (.clock(clock), .rst_n(rst_n));

  ex_stage #(.MULT_STAGES(MULT_STAGES)) ex_stage_inst (
    .clock    (clock),
    .rst_n    (rst_n),
    .issue_1  (issue_1),
    .issue_2  (issue_2),
    .result_1 (result_1),
    .result_2 (result_2),
    .stall_1  (stall_1),
    .stall_2  (stall_2)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  function automatic logic [63:0] operand_a(issue_pkt_t p);
    case (p.opa_sel)
      OPA_IS_REGA:     return p.rega;
      OPA_IS_MEM_DISP: return {{48{p.ir.mem.disp[15]}}, p.ir.mem.disp};
      OPA_IS_NPC:      return p.npc;
      default:         return ~64'd3;
    endcase
  endfunction

  function automatic logic [63:0] operand_b(issue_pkt_t p);
    case (p.opb_sel)
      OPB_IS_REGB:    return p.regb;
      OPB_IS_ALU_IMM: return {56'b0, p.ir.op.src.lit};
      default:        return {{41{p.ir.br.disp[20]}}, p.ir.br.disp, 2'b00};   // Longwords
    endcase
  endfunction

  function automatic logic [63:0] alu_model(logic [63:0] a, logic [63:0] b, logic [4:0] f);
    case (f)
      ALU_ADDQ:   return a + b;
      ALU_SUBQ:   return a - b;
      ALU_AND:    return a & b;
      ALU_BIC:    return a & ~b;
      ALU_BIS:    return a | b;
      ALU_ORNOT:  return a | ~b;
      ALU_XOR:    return a ^ b;
      ALU_EQV:    return ~(a ^ b);
      ALU_SRL:    return a >> b[5:0];
      ALU_SLL:    return a << b[5:0];
      ALU_SRA:    return 64'($signed(a) >>> b[5:0]);
      ALU_CMPEQ:  return {63'b0, a == b};
      ALU_CMPLT:  return {63'b0, $signed(a) < $signed(b)};
      ALU_CMPLE:  return {63'b0, $signed(a) <= $signed(b)};
      ALU_CMPULT: return {63'b0, a < b};
      ALU_CMPULE: return {63'b0, a <= b};
      default:    return 64'b0;
    endcase
  endfunction

  function automatic logic cond_holds(logic [63:0] v, logic [2:0] c);
    case (c)
      3'd0:    return !v[0];
      3'd1:    return v == 64'b0;
      3'd2:    return $signed(v) < 0;
      3'd3:    return $signed(v) <= 0;
      3'd4:    return v[0];
      3'd5:    return v != 64'b0;
      3'd6:    return $signed(v) >= 0;
      default: return $signed(v) > 0;
    endcase
  endfunction

  function automatic logic [63:0] correct_pc(issue_pkt_t p);
    logic taken;
    taken = p.uncond_branch || (p.cond_branch && cond_holds(p.rega, p.ir.br.opcode[2:0]));
    return taken ? alu_model(operand_a(p), operand_b(p), p.alu_func) : p.npc;
  endfunction

  function automatic ex_result_t expected_result(issue_pkt_t p);
    ex_result_t r;
    r.valid    = 1'b1;
    r.dest_reg = p.dest_reg;
    if (p.alu_func == ALU_MULQ)
    begin
      r.value      = operand_a(p) * operand_b(p);   // Low 64 bits
      r.mispredict = 1'b0;
    end
    else
    begin
      r.value      = alu_model(operand_a(p), operand_b(p), p.alu_func);
      r.mispredict = correct_pc(p) != p.ppc;
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bookkeeping
  task automatic check(input string what, input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  always @(posedge clock)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // Compare every valid result against its scoreboard entry
  always @(negedge clock)
  begin
    ex_result_t r;
    if (rst_n)
      for (int l = 0; l < 2; l++)
      begin
        r = (l == 0) ? result_1 : result_2;
        if (r.valid && !in_flight[l][r.dest_reg])
        begin
          errors++;
          $display("lane %0d: result for r%0d arrived with nothing outstanding",
                   l + 1, r.dest_reg);
        end
        else if (r.valid)
        begin
          check("value", exp_res[l][r.dest_reg].value, r.value);
          check("mispredict", 64'(exp_res[l][r.dest_reg].mispredict), 64'(r.mispredict));
          check("arrival cycle", 64'(due[l][r.dest_reg]), 64'(cyc));
          in_flight[l][r.dest_reg] = 1'b0;
        end
        for (int d = 0; d < 32; d++)
          if (in_flight[l][d] && cyc > due[l][d])
          begin
            errors++;
            $display("lane %0d: result for r%0d never arrived", l + 1, d);
            in_flight[l][d] = 1'b0;
          end
      end
  end

  function automatic logic [4:0] free_dest(int l);
    logic [4:0] d;
    do d = 5'($urandom % 32); while (in_flight[l][d]);
    return d;
  endfunction

  function automatic issue_pkt_t make_op(int l, logic [4:0] f, logic [1:0] sa, logic [1:0] sb);
    issue_pkt_t p;
    p          = '0;
    p.valid    = 1'b1;
    p.npc      = {$urandom, $urandom} & ~64'd3;
    p.ppc      = p.npc;                // Falls through, no mispredict
    p.ir       = $urandom;
    p.dest_reg = free_dest(l);
    p.rega     = {$urandom, $urandom};
    p.regb     = {$urandom, $urandom};
    p.opa_sel  = sa;
    p.opb_sel  = sb;
    p.alu_func = f;
    return p;
  endfunction

  // Drive both lanes, holding each packet while its lane stalls
  task automatic issue_pair(input issue_pkt_t p1, input issue_pkt_t p2);
    issue_pkt_t pend [2];
    logic       busy [2];
    logic       s;
    int         lat;
    pend[0] = p1;
    pend[1] = p2;
    busy[0] = p1.valid;
    busy[1] = p2.valid;
    do
    begin
      @(negedge clock);
      issue_1 = busy[0] ? pend[0] : '0;
      issue_2 = busy[1] ? pend[1] : '0;
      #1;
      for (int l = 0; l < 2; l++)
        if (busy[l])
        begin
          s = (l == 0) ? stall_1 : stall_2;
          if (s)
            stalls_seen[l]++;
          else
          begin
            lat = (pend[l].alu_func == ALU_MULQ) ? MULT_STAGES + 1 : 1;
            exp_res[l][pend[l].dest_reg]   = expected_result(pend[l]);
            due[l][pend[l].dest_reg]       = cyc + lat;   // Accepted at next edge
            in_flight[l][pend[l].dest_reg] = 1'b1;
            busy[l] = 1'b0;
          end
        end
    end
    while (busy[0] || busy[1]);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge clock);
      issue_1 = '0;
      issue_2 = '0;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test();
    idle_cycles(MULT_STAGES + 4);   // Drain the lanes
    $display("test %s: %0d checks, %s", test_name, checks - test_checks,
             (errors == test_errors) ? "ok" : "FAILED");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  initial
  begin
    issue_pkt_t p [2];
    logic [63:0] vals [6];
    cyc     = 0;
    checks  = 0;
    errors  = 0;
    issue_1 = '0;
    issue_2 = '0;
    in_flight = '{default: '{default: 1'b0}};
    stalls_seen = '{0, 0};
    void'($urandom(32'h3db3_4990));

    begin_test("reset");
    @(posedge clock);
    while (!rst_n)
    begin
      @(negedge clock);
      check("valids and stalls", 64'b0,
            64'({result_1.valid, result_2.valid, stall_1, stall_2}));
    end
    @(negedge clock);
    check("valids and stalls", 64'b0, 64'({result_1.valid, result_2.valid, stall_1, stall_2}));
    end_test();

    begin_test("alu_functions");
    for (int rep = 0; rep < 6; rep++)
      for (int f = 0; f <= 16; f++)
        if (5'(f) != ALU_MULQ)
        begin
          for (int l = 0; l < 2; l++)
          begin
            p[l] = make_op(l, 5'(f), OPA_IS_REGA, 2'($urandom % 2));
            if ($urandom % 4 == 0)
              p[l].regb = 64'd63 + 64'($urandom % 3);   // Counts 63, 64, 65
            if ($urandom % 5 == 0)
              p[l].regb = p[l].rega;                    // Equal compares
          end
          issue_pair(p[0], p[1]);
        end
    end_test();

    begin_test("operand_select");
    for (int i = 0; i < 40; i++)
    begin
      for (int l = 0; l < 2; l++)
        p[l] = make_op(l, ALU_ADDQ, 2'(1 + $urandom % 3), 2'($urandom % 3));
      issue_pair(p[0], p[1]);
    end
    end_test();

    begin_test("branches");
    vals = '{64'd0, 64'd1, 64'd2, ~64'd0, ~64'd1, 64'd0};
    for (int c = 0; c < 8; c++)
      for (int v = 0; v < 6; v++)
        for (int wrong = 0; wrong < 2; wrong++)
        begin
          for (int l = 0; l < 2; l++)
          begin
            p[l] = make_op(l, ALU_ADDQ, OPA_IS_NPC, OPB_IS_BR_DISP);
            p[l].ir.br.opcode[2:0] = 3'(c);
            p[l].rega = (v == 5) ? {$urandom, $urandom} : vals[v];
            p[l].cond_branch   = (c + v) % 7 != 0;
            p[l].uncond_branch = !p[l].cond_branch;   // Some unconditional
            p[l].ppc = correct_pc(p[l]) + ((wrong == 1) ? 64'd4 : 64'd0);
          end
          issue_pair(p[0], p[1]);
        end
    end_test();

    begin_test("multiplies");
    for (int i = 0; i < 40; i++)
    begin
      for (int l = 0; l < 2; l++)
        p[l] = make_op(l, ALU_MULQ, OPA_IS_REGA, 2'($urandom % 2));
      issue_pair(p[0], p[1]);
    end
    end_test();

    begin_test("collision");
    stalls_seen = '{0, 0};
    issue_pair(make_op(0, ALU_MULQ, OPA_IS_REGA, OPB_IS_REGB),
               make_op(1, ALU_ADDQ, OPA_IS_REGA, OPB_IS_REGB));
    for (int i = 0; i < 8; i++)
      issue_pair(make_op(0, 5'($urandom % 11), OPA_IS_REGA, OPB_IS_REGB),
                 make_op(1, ALU_XOR, OPA_IS_REGA, OPB_IS_ALU_IMM));
    check("lane 1 stall raised", 64'd1, 64'(stalls_seen[0] > 0));
    check("lane 2 stall count", 64'd0, 64'(stalls_seen[1]));
    end_test();

    for (int l = 0; l < 2; l++)
      for (int d = 0; d < 32; d++)
        if (in_flight[l][d])
        begin
          errors++;
          $display("lane %0d: result for r%0d still outstanding at the end", l + 1, d);
        end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
